// File: design/wb_pkg.sv
`default_nettype none

package wb_pkg;

	// Vector geometry
	localparam int WORD_BITS = 32;
	localparam int LANES = 16;
	localparam int LINE_BITS = WORD_BITS * LANES;

	// Register numbering
	localparam int STRAND_BITS = 2;
	localparam int REG_INDEX_BITS = 5;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [LANES-1:0] lane_mask_t;
	typedef logic [$clog2(LANES)-1:0] lane_index_t;

	// Strand in the top two bits, register index below
	typedef logic [STRAND_BITS+REG_INDEX_BITS-1:0] reg_num_t;

	// Scalar register index that aliases the PC
	localparam logic [REG_INDEX_BITS-1:0] PC_INDEX = 5'd31;

	// Format C (memory) instructions carry this in bits 31:30
	localparam logic [1:0] FMT_C_TAG = 2'b10;

	localparam lane_mask_t FULL_MASK = '1;

	// Memory operation, instruction bits 28:25
	typedef enum logic [3:0] {
		MEM_B = 4'd0,
		MEM_BX = 4'd1,
		MEM_S = 4'd2,
		MEM_SX = 4'd3,
		MEM_L = 4'd4,
		MEM_SYNC = 4'd5,
		MEM_CONTROL_REG = 4'd6,
		MEM_BLOCK = 4'd7,
		MEM_BLOCK_M = 4'd8,
		MEM_BLOCK_IM = 4'd9,
		MEM_STRIDED = 4'd10,
		MEM_STRIDED_M = 4'd11,
		MEM_STRIDED_IM = 4'd12,
		MEM_GATHER = 4'd13,
		MEM_GATHER_M = 4'd14,
		MEM_GATHER_IM = 4'd15
	} mem_op_t;

endpackage

`default_nettype wire

// File: design/lane_select_mux.sv
`default_nettype none

module lane_select_mux (
	input wire wb_pkg::line_t value,
	input wire wb_pkg::lane_index_t lane_select,
	output wb_pkg::word_t lane_value
);

	// Line split into words, lane 0 in the low bits
	wb_pkg::word_t lanes [wb_pkg::LANES];

	always_comb
	begin
		for (int i = 0; i < wb_pkg::LANES; i++)
		begin
			lanes[i] = value[i * wb_pkg::WORD_BITS +: wb_pkg::WORD_BITS];
		end
	end

	assign lane_value = lanes[lane_select];

endmodule

`default_nettype wire

// File: design/load_aligner.sv
`default_nettype none

module load_aligner (
	input wire wb_pkg::word_t lane_value,
	input wire [1:0] byte_offset,
	input wire wb_pkg::mem_op_t op,
	output wb_pkg::word_t aligned_value
);

	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;

	// Big-endian lane, offset 0 is the top byte
	always_comb
	begin
		case (byte_offset)
			2'd0: byte_aligned = lane_value[31:24];
			2'd1: byte_aligned = lane_value[23:16];
			2'd2: byte_aligned = lane_value[15:8];
			default: byte_aligned = lane_value[7:0];
		endcase
	end

	// Halfword comes back with its bytes swapped
	always_comb
	begin
		if (byte_offset[1])
		begin
			half_aligned = {lane_value[7:0], lane_value[15:8]};
		end
		else
		begin
			half_aligned = {lane_value[23:16], lane_value[31:24]};
		end
	end

	always_comb
	begin
		case (op)
			wb_pkg::MEM_B:
				aligned_value = {24'b0, byte_aligned};
			wb_pkg::MEM_BX:
				aligned_value = {{24{byte_aligned[7]}}, byte_aligned};
			wb_pkg::MEM_S:
				aligned_value = {16'b0, half_aligned};
			wb_pkg::MEM_SX:
				aligned_value = {{16{half_aligned[15]}}, half_aligned};
			default:
			begin
				// Full word, byte-reversed
				aligned_value = {lane_value[7:0], lane_value[15:8],
					lane_value[23:16], lane_value[31:24]};
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/writeback_stage.sv
`default_nettype none

module writeback_stage (
	input wire clk,
	input wire reset,
	input wire wb_pkg::word_t ma_instruction,
	input wire wb_pkg::word_t ma_pc,
	input wire wb_pkg::reg_num_t ma_writeback_reg,
	input wire ma_writeback_is_vector,
	input wire ma_has_writeback,
	input wire wb_pkg::lane_mask_t ma_mask,
	input wire ma_was_access,
	input wire wb_pkg::line_t ma_result,
	input wire wb_pkg::lane_index_t ma_reg_lane_select,
	input wire wb_pkg::lane_index_t ma_cache_lane_select,
	input wire dcache_hit,
	input wire dcache_load_collision,
	input wire stbuf_rollback,
	input wire wb_pkg::line_t data_from_dcache,
	output logic wb_writeback_is_vector,
	output logic wb_has_writeback,
	output wb_pkg::reg_num_t wb_writeback_reg,
	output wb_pkg::line_t wb_writeback_value,
	output wb_pkg::lane_mask_t wb_writeback_mask,
	output logic wb_rollback_request,
	output wb_pkg::word_t wb_rollback_pc,
	output logic wb_suspend_request
);

	logic is_fmt_c;
	logic is_load;
	logic is_sync_store;
	logic is_control_transfer;
	logic is_block_load;
	logic cache_miss;
	logic pc_load;
	logic do_writeback;
	wb_pkg::mem_op_t c_op;
	wb_pkg::lane_index_t cache_lane;
	wb_pkg::word_t lane_value;
	wb_pkg::word_t aligned_value;
	wb_pkg::line_t swapped_line;
	wb_pkg::line_t writeback_value_nxt;
	wb_pkg::lane_mask_t mask_nxt;

	// Instruction decode
	assign is_fmt_c = ma_instruction[31:30] == wb_pkg::FMT_C_TAG;
	assign is_load = is_fmt_c && ma_instruction[29];
	assign c_op = wb_pkg::mem_op_t'(ma_instruction[28:25]);
	assign is_sync_store = is_fmt_c && !ma_instruction[29] && c_op == wb_pkg::MEM_SYNC;
	assign is_control_transfer = is_fmt_c && c_op == wb_pkg::MEM_CONTROL_REG;
	assign is_block_load = c_op == wb_pkg::MEM_BLOCK || c_op == wb_pkg::MEM_BLOCK_M
		|| c_op == wb_pkg::MEM_BLOCK_IM;

	assign cache_miss = !dcache_hit && ma_was_access && is_load && !dcache_load_collision;
	assign pc_load = ma_has_writeback && !ma_writeback_is_vector
		&& ma_writeback_reg[4:0] == wb_pkg::PC_INDEX && is_load;

	// Lane 0 of the line is the most significant word
	assign cache_lane = 4'd15 - ma_cache_lane_select;

	lane_select_mux u_lane_select_mux (
		.value(data_from_dcache),
		.lane_select(cache_lane),
		.lane_value(lane_value)
	);

	// Low address bits still sit in ma_result
	load_aligner u_load_aligner (
		.lane_value(lane_value),
		.byte_offset(ma_result[1:0]),
		.op(c_op),
		.aligned_value(aligned_value)
	);

	// Byte reverse within every lane for block loads
	always_comb
	begin
		for (int i = 0; i < wb_pkg::LANES; i++)
		begin
			swapped_line[i * 32 +: 32] = {data_from_dcache[i * 32 +: 8],
				data_from_dcache[i * 32 + 8 +: 8], data_from_dcache[i * 32 + 16 +: 8],
				data_from_dcache[i * 32 + 24 +: 8]};
		end
	end

	// Writeback source and lane mask
	always_comb
	begin
		if (is_sync_store)
		begin
			// Success flag comes back in the cache line
			writeback_value_nxt = data_from_dcache;
			mask_nxt = wb_pkg::FULL_MASK;
		end
		else if (is_load && !is_control_transfer && c_op < wb_pkg::MEM_BLOCK)
		begin
			writeback_value_nxt = {wb_pkg::LANES{aligned_value}};
			mask_nxt = wb_pkg::FULL_MASK;
		end
		else if (is_load && is_block_load)
		begin
			writeback_value_nxt = swapped_line;
			mask_nxt = ma_mask;
		end
		else if (is_load && !is_control_transfer)
		begin
			// Strided or gather, one lane per cycle
			writeback_value_nxt = {wb_pkg::LANES{aligned_value}};
			mask_nxt = (wb_pkg::lane_mask_t'(1) << ma_reg_lane_select) & ma_mask;
		end
		else
		begin
			writeback_value_nxt = ma_result;
			mask_nxt = ma_mask;
		end
	end

	// Rollback, in priority order
	always_comb
	begin
		if (dcache_load_collision || cache_miss || stbuf_rollback)
		begin
			// Collision, miss or store buffer rollback retries the instruction
			wb_rollback_request = 1'b1;
			wb_rollback_pc = ma_pc - 32'd4;
		end
		else if (pc_load)
		begin
			// Load into PC is a jump to the loaded value
			wb_rollback_request = 1'b1;
			wb_rollback_pc = aligned_value;
		end
		else
		begin
			wb_rollback_request = 1'b0;
			wb_rollback_pc = '0;
		end
	end

	assign wb_suspend_request = cache_miss || stbuf_rollback;
	assign do_writeback = ma_has_writeback && !wb_rollback_request;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb_has_writeback <= 1'b0;
		end
		else
		begin
			wb_has_writeback <= do_writeback;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_writeback_value <= writeback_value_nxt;
		wb_writeback_mask <= mask_nxt;
		wb_writeback_is_vector <= ma_writeback_is_vector;
		wb_writeback_reg <= ma_writeback_reg;
	end

endmodule

`default_nettype wire

// File: design/vector_register_file.sv
`default_nettype none

module vector_register_file (
	input wire clk,
	input wire wb_has_writeback,
	input wire wb_writeback_is_vector,
	input wire wb_pkg::reg_num_t wb_writeback_reg,
	input wire wb_pkg::line_t wb_writeback_value,
	input wire wb_pkg::lane_mask_t wb_writeback_mask,
	input wire wb_pkg::reg_num_t read_reg,
	output wb_pkg::word_t read_scalar,
	output wb_pkg::line_t read_vector
);

	localparam int NUM_REGS = 2 ** $bits(wb_pkg::reg_num_t);

	// Four strands of 32 registers each
	wb_pkg::word_t scalar_regs [NUM_REGS];
	wb_pkg::line_t vector_regs [NUM_REGS];

	// Scalar writes take lane 0 of the value
	always_ff @(posedge clk)
	begin
		if (wb_has_writeback && !wb_writeback_is_vector)
		begin
			scalar_regs[wb_writeback_reg] <= wb_writeback_value[wb_pkg::WORD_BITS-1:0];
		end
	end

	// Vector writes touch only enabled lanes
	always_ff @(posedge clk)
	begin
		if (wb_has_writeback && wb_writeback_is_vector)
		begin
			for (int i = 0; i < wb_pkg::LANES; i++)
			begin
				if (wb_writeback_mask[i])
				begin
					vector_regs[wb_writeback_reg][i * wb_pkg::WORD_BITS +: wb_pkg::WORD_BITS]
						<= wb_writeback_value[i * wb_pkg::WORD_BITS +: wb_pkg::WORD_BITS];
				end
			end
		end
	end

	// Observation port
	assign read_scalar = scalar_regs[read_reg];
	assign read_vector = vector_regs[read_reg];

endmodule

`default_nettype wire

// File: design/writeback_top.sv
`default_nettype none

module writeback_top (
	input wire clk,
	input wire reset,
	input wire wb_pkg::word_t ma_instruction,
	input wire wb_pkg::word_t ma_pc,
	input wire wb_pkg::reg_num_t ma_writeback_reg,
	input wire ma_writeback_is_vector,
	input wire ma_has_writeback,
	input wire wb_pkg::lane_mask_t ma_mask,
	input wire ma_was_access,
	input wire wb_pkg::line_t ma_result,
	input wire wb_pkg::lane_index_t ma_reg_lane_select,
	input wire wb_pkg::lane_index_t ma_cache_lane_select,
	input wire dcache_hit,
	input wire dcache_load_collision,
	input wire stbuf_rollback,
	input wire wb_pkg::line_t data_from_dcache,
	output wire wb_writeback_is_vector,
	output wire wb_has_writeback,
	output wire wb_pkg::reg_num_t wb_writeback_reg,
	output wire wb_pkg::line_t wb_writeback_value,
	output wire wb_pkg::lane_mask_t wb_writeback_mask,
	output wire wb_rollback_request,
	output wire wb_pkg::word_t wb_rollback_pc,
	output wire wb_suspend_request,
	input wire wb_pkg::reg_num_t read_reg,
	output wire wb_pkg::word_t read_scalar,
	output wire wb_pkg::line_t read_vector
);

	writeback_stage u_writeback_stage (
		.clk(clk),
		.reset(reset),
		.ma_instruction(ma_instruction),
		.ma_pc(ma_pc),
		.ma_writeback_reg(ma_writeback_reg),
		.ma_writeback_is_vector(ma_writeback_is_vector),
		.ma_has_writeback(ma_has_writeback),
		.ma_mask(ma_mask),
		.ma_was_access(ma_was_access),
		.ma_result(ma_result),
		.ma_reg_lane_select(ma_reg_lane_select),
		.ma_cache_lane_select(ma_cache_lane_select),
		.dcache_hit(dcache_hit),
		.dcache_load_collision(dcache_load_collision),
		.stbuf_rollback(stbuf_rollback),
		.data_from_dcache(data_from_dcache),
		.wb_writeback_is_vector(wb_writeback_is_vector),
		.wb_has_writeback(wb_has_writeback),
		.wb_writeback_reg(wb_writeback_reg),
		.wb_writeback_value(wb_writeback_value),
		.wb_writeback_mask(wb_writeback_mask),
		.wb_rollback_request(wb_rollback_request),
		.wb_rollback_pc(wb_rollback_pc),
		.wb_suspend_request(wb_suspend_request)
	);

	// Registered writeback commits here on the next edge
	vector_register_file u_vector_register_file (
		.clk(clk),
		.wb_has_writeback(wb_has_writeback),
		.wb_writeback_is_vector(wb_writeback_is_vector),
		.wb_writeback_reg(wb_writeback_reg),
		.wb_writeback_value(wb_writeback_value),
		.wb_writeback_mask(wb_writeback_mask),
		.read_reg(read_reg),
		.read_scalar(read_scalar),
		.read_vector(read_vector)
	);

endmodule

`default_nettype wire

// File: testbench/tb_writeback_top.sv
`default_nettype none

module tb_writeback_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TRANSACTIONS = 2000;
	localparam int RESET_CYCLES = 8;
	// Run needs about reset plus one cycle per transaction, so allow three times that
	localparam int TIMEOUT_CYCLES = 3 * NUM_TRANSACTIONS;

	logic clk = 1'b0;
	logic reset;
	wb_pkg::word_t ma_instruction;
	wb_pkg::word_t ma_pc;
	wb_pkg::reg_num_t ma_writeback_reg;
	logic ma_writeback_is_vector;
	logic ma_has_writeback;
	wb_pkg::lane_mask_t ma_mask;
	logic ma_was_access;
	wb_pkg::line_t ma_result;
	wb_pkg::lane_index_t ma_reg_lane_select;
	wb_pkg::lane_index_t ma_cache_lane_select;
	logic dcache_hit;
	logic dcache_load_collision;
	logic stbuf_rollback;
	wb_pkg::line_t data_from_dcache;
	wb_pkg::reg_num_t read_reg;
	wire wb_writeback_is_vector;
	wire wb_has_writeback;
	wire wb_pkg::reg_num_t wb_writeback_reg;
	wire wb_pkg::line_t wb_writeback_value;
	wire wb_pkg::lane_mask_t wb_writeback_mask;
	wire wb_rollback_request;
	wire wb_pkg::word_t wb_rollback_pc;
	wire wb_suspend_request;
	wire wb_pkg::word_t read_scalar;
	wire wb_pkg::line_t read_vector;

	// Writeback the DUT should present during the current cycle
	logic pend_has_wb = 1'b0;
	logic pend_vector;
	wb_pkg::reg_num_t pend_reg;
	wb_pkg::line_t pend_value;
	wb_pkg::lane_mask_t pend_mask;

	// Shadow register file
	wb_pkg::word_t scalar_shadow [128];
	wb_pkg::line_t vector_shadow [128];
	logic scalar_written [128];
	wb_pkg::lane_mask_t lanes_written [128];

	int error_count = 0;
	int cycle_count = 0;

	writeback_top u_writeback_top (.*);

	initial
	begin
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "Timeout");
		end
	end

	task automatic report_mismatch(input string what);
		error_count++;
		$display("[FAIL] %0t ns: %s", $time, what);
		$display("=== FAIL ===");
		$fatal(1, "Stopping at the first mismatch");
	endtask

	// Byte k in big-endian order, k = 0 is the top byte
	function automatic logic [7:0] be_byte(input wb_pkg::word_t w, input logic [1:0] k);
		return 8'(w >> (8 * (3 - int'(k))));
	endfunction

	function automatic wb_pkg::word_t reverse_bytes(input wb_pkg::word_t w);
		return {be_byte(w, 2'd3), be_byte(w, 2'd2), be_byte(w, 2'd1), be_byte(w, 2'd0)};
	endfunction

	function automatic wb_pkg::word_t model_load_value(input wb_pkg::word_t w,
		input logic [1:0] offset, input logic [3:0] op);
		logic [7:0] b;
		logic [15:0] h;
		wb_pkg::word_t value;
		b = be_byte(w, offset);
		// Halfword arrives with its two bytes swapped
		h = {be_byte(w, {offset[1], 1'b1}), be_byte(w, {offset[1], 1'b0})};
		case (op)
			wb_pkg::MEM_B: value = {24'd0, b};
			wb_pkg::MEM_BX: value = {{24{b[7]}}, b};
			wb_pkg::MEM_S: value = {16'd0, h};
			wb_pkg::MEM_SX: value = {{16{h[15]}}, h};
			default: value = reverse_bytes(w);
		endcase
		return value;
	endfunction

	function automatic wb_pkg::line_t random_line();
		wb_pkg::line_t line;
		for (int i = 0; i < 16; i++)
		begin
			line[i * 32 +: 32] = $urandom;
		end
		return line;
	endfunction

	task automatic check_read_port;
		int r;
		r = int'(read_reg);
		if (scalar_written[r])
		begin
			assert (read_scalar == scalar_shadow[r])
			else report_mismatch($sformatf("scalar reg %0d read %h expected %h",
				r, read_scalar, scalar_shadow[r]));
		end
		for (int i = 0; i < 16; i++)
		begin
			if (lanes_written[r][i])
			begin
				assert (read_vector[i * 32 +: 32] == vector_shadow[r][i * 32 +: 32])
				else report_mismatch($sformatf("vector reg %0d lane %0d read %h expected %h",
					r, i, read_vector[i * 32 +: 32], vector_shadow[r][i * 32 +: 32]));
			end
		end
	endtask

	task automatic check_and_commit;
		int r;
		r = int'(pend_reg);
		assert (wb_has_writeback == pend_has_wb)
		else report_mismatch($sformatf("wb_has_writeback %b expected %b",
			wb_has_writeback, pend_has_wb));
		if (!pend_has_wb)
			return;
		assert (wb_writeback_reg == pend_reg && wb_writeback_is_vector == pend_vector)
		else report_mismatch($sformatf("writeback reg %h vector %b expected %h vector %b",
			wb_writeback_reg, wb_writeback_is_vector, pend_reg, pend_vector));
		assert (wb_writeback_mask == pend_mask)
		else report_mismatch($sformatf("writeback mask %h expected %h",
			wb_writeback_mask, pend_mask));
		assert (wb_writeback_value == pend_value)
		else report_mismatch($sformatf("writeback value %h expected %h",
			wb_writeback_value, pend_value));
		// Register file takes this on the coming edge
		if (pend_vector)
		begin
			for (int i = 0; i < 16; i++)
			begin
				if (pend_mask[i])
				begin
					vector_shadow[r][i * 32 +: 32] = pend_value[i * 32 +: 32];
					lanes_written[r][i] = 1'b1;
				end
			end
		end
		else
		begin
			scalar_shadow[r] = pend_value[31:0];
			scalar_written[r] = 1'b1;
		end
	endtask

	// Checks rollback for the current inputs and predicts next cycle's writeback
	task automatic model_stage;
		logic fmt_c;
		logic load;
		logic [3:0] op;
		logic miss;
		logic rollback;
		wb_pkg::word_t target;
		wb_pkg::word_t loaded;
		fmt_c = ma_instruction[31:30] == wb_pkg::FMT_C_TAG;
		load = fmt_c && ma_instruction[29];
		op = ma_instruction[28:25];
		// Cache lane 0 is the top word of the line
		loaded = model_load_value(data_from_dcache[(15 - int'(ma_cache_lane_select)) * 32 +: 32],
			ma_result[1:0], op);
		miss = load && ma_was_access && !dcache_hit && !dcache_load_collision;
		rollback = 1'b1;
		if (dcache_load_collision || miss || stbuf_rollback)
			target = ma_pc - 32'd4;
		else if (load && ma_has_writeback && !ma_writeback_is_vector
			&& ma_writeback_reg[4:0] == 5'd31)
			target = loaded;
		else
		begin
			rollback = 1'b0;
			target = '0;
		end
		assert (wb_rollback_request == rollback && wb_suspend_request == (miss || stbuf_rollback))
		else report_mismatch($sformatf("rollback %b suspend %b expected %b %b",
			wb_rollback_request, wb_suspend_request, rollback, miss || stbuf_rollback));
		if (rollback)
		begin
			assert (wb_rollback_pc == target)
			else report_mismatch($sformatf("rollback pc %h expected %h", wb_rollback_pc, target));
		end
		pend_has_wb = ma_has_writeback && !rollback;
		pend_reg = ma_writeback_reg;
		pend_vector = ma_writeback_is_vector;
		pend_value = ma_result;
		pend_mask = ma_mask;
		if (fmt_c && !ma_instruction[29] && op == wb_pkg::MEM_SYNC)
		begin
			pend_value = data_from_dcache;
			pend_mask = '1;
		end
		else if (load && op <= wb_pkg::MEM_SYNC)
		begin
			pend_value = {16{loaded}};
			pend_mask = '1;
		end
		else if (load && op >= wb_pkg::MEM_BLOCK && op <= wb_pkg::MEM_BLOCK_IM)
		begin
			for (int i = 0; i < 16; i++)
			begin
				pend_value[i * 32 +: 32] = reverse_bytes(data_from_dcache[i * 32 +: 32]);
			end
		end
		else if (load && op >= wb_pkg::MEM_STRIDED)
		begin
			pend_value = {16{loaded}};
			pend_mask = (16'd1 << ma_reg_lane_select) & ma_mask;
		end
	endtask

	always @(negedge clk)
	begin
		if (reset)
		begin
			pend_has_wb = 1'b0;
			for (int r = 0; r < 128; r++)
			begin
				scalar_written[r] = 1'b0;
				lanes_written[r] = '0;
			end
		end
		else
		begin
			check_read_port();
			check_and_commit();
			model_stage();
		end
	end

	task automatic drive_idle;
		ma_instruction <= '0;
		ma_pc <= '0;
		ma_writeback_reg <= '0;
		ma_writeback_is_vector <= 1'b0;
		ma_has_writeback <= 1'b0;
		ma_mask <= '0;
		ma_was_access <= 1'b0;
		ma_result <= '0;
		ma_reg_lane_select <= '0;
		ma_cache_lane_select <= '0;
		dcache_hit <= 1'b1;
		dcache_load_collision <= 1'b0;
		stbuf_rollback <= 1'b0;
		data_from_dcache <= '0;
		read_reg <= '0;
	endtask

	task automatic drive_transaction;
		logic [31:0] r;
		logic [31:0] flags;
		wb_pkg::word_t instr;
		r = $urandom;
		flags = $urandom;
		instr = $urandom;
		// Three in four are memory instructions
		if (r[1:0] != 2'b00)
			instr[31:30] = wb_pkg::FMT_C_TAG;
		else if (instr[31:30] == wb_pkg::FMT_C_TAG)
			instr[31:30] = 2'b11;
		ma_instruction <= instr;
		ma_pc <= $urandom;
		// One in eight aims at the PC index
		ma_writeback_reg <= (r[4:2] == 3'd0) ? {r[6:5], 5'd31} : r[13:7];
		ma_writeback_is_vector <= r[14];
		ma_has_writeback <= r[16:15] != 2'b00;
		ma_mask <= 16'($urandom);
		ma_was_access <= r[18:17] != 2'b00;
		ma_result <= random_line();
		ma_reg_lane_select <= r[22:19];
		ma_cache_lane_select <= r[26:23];
		dcache_hit <= r[29:27] != 3'd0;
		dcache_load_collision <= flags[3:0] == 4'd0;
		stbuf_rollback <= flags[7:4] == 4'd0;
		data_from_dcache <= random_line();
		read_reg <= 7'($urandom);
	endtask

	initial
	begin
		void'($urandom(2));
		reset = 1'b1;
		drive_idle();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		for (int n = 0; n < NUM_TRANSACTIONS; n++)
		begin
			@(posedge clk);
			drive_transaction();
		end
		@(posedge clk);
		drive_idle();
		// Let the last writebacks reach the register file
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (error_count == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
		begin
			$display("=== FAIL ===");
			$fatal(1, "Mismatches found");
		end
	end

endmodule

`default_nettype wire

// File: flist.f
design/wb_pkg.sv
design/lane_select_mux.sv
design/load_aligner.sv
design/writeback_stage.sv
design/vector_register_file.sv
design/writeback_top.sv
testbench/tb_writeback_top.sv

// File: run.sh
#!/bin/sh
# Builds and runs the writeback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_writeback_top -o sim_writeback

./obj_dir/sim_writeback 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
